// ==== ccPkg.sv ====
package ccPkg;

    // number of vertices of the 7-cube.
    // every graph and vertex-set bus is this wide.
    localparam int VERTEX_COUNT = 128;

    // hypercube dimension.
    // two vertices are adjacent when their indices differ in one bit.
    localparam int DIMENSION = 7;

    // singleton count width.
    // an independent set of the 7-cube holds at most 64 vertices.
    // the count therefore spans 0 to 64 and needs seven bits.
    localparam int SINGLETON_WIDTH = 7;

    // total component count width.
    // every component holds a vertex of some independent set, so the total stays at or below 64.
    localparam int COMPONENT_WIDTH = 7;

    // cycles from the splitter enable strobe to valid split outputs.
    localparam int SPLIT_LATENCY = 3;

    // cycles from a valid singleton set to a valid singleton count.
    localparam int POPCNT_LATENCY = 4;

    // controller states.
    typedef enum logic [2:0] {
        IDLE,
        SPLIT,
        EXPLORE,
        WAIT_COUNT,
        FINISH
    } ctrlState;

endpackage

// ==== singletonSplitter.sv ====
`timescale 1ns/1ps

module singletonSplitter (
    input  logic                           clk,
    input  logic                           clkEnPre,
    input  logic                           zeroNonSingletons,
    input  logic [ccPkg::VERTEX_COUNT-1:0] graphIn,
    output logic [ccPkg::VERTEX_COUNT-1:0] singletons,
    output logic [ccPkg::VERTEX_COUNT-1:0] nonSingletons
);

    // dimensions handled by the first stage.
    localparam int LOW_DIMS = 5;
    localparam int HIGH_DIMS = ccPkg::DIMENSION - LOW_DIMS;

    // separate enable copies per register group to keep fanout local.
    logic       clkEnDNeighbors;
    logic [1:0] clkEnDSingletons;
    logic [1:0] clkEnDNonSingletons;

    logic [ccPkg::VERTEX_COUNT-1:0] lowFlag;
    logic [ccPkg::VERTEX_COUNT-1:0] lowFlagD;
    logic [ccPkg::VERTEX_COUNT-1:0] graphD;
    logic [ccPkg::VERTEX_COUNT-1:0] hasNeighbor;

    always_ff @(posedge clk) begin
        clkEnDNeighbors <= clkEnPre;
        clkEnDSingletons <= {clkEnDSingletons[0], clkEnPre};
        clkEnDNonSingletons <= {clkEnDNonSingletons[0], clkEnPre};
    end

    for (genvar vtx = 0; vtx < ccPkg::VERTEX_COUNT; vtx++) begin : gVertex
        logic [LOW_DIMS-1:0]  lowDims;
        logic [HIGH_DIMS-1:0] highDims;

        // the neighbour across dimension d sits at index vtx ^ (1 << d).
        for (genvar d = 0; d < LOW_DIMS; d++) begin : gLow
            assign lowDims[d] = graphIn[vtx ^ (1 << d)];
        end

        // upper dimensions come from the registered graph copy.
        for (genvar d = LOW_DIMS; d < ccPkg::DIMENSION; d++) begin : gHigh
            assign highDims[d - LOW_DIMS] = graphD[vtx ^ (1 << d)];
        end

        assign lowFlag[vtx] = |lowDims;
        assign hasNeighbor[vtx] = lowFlagD[vtx] | (|highDims);
    end

    // first stage.
    always_ff @(posedge clk) begin
        if (clkEnDNeighbors) begin
            lowFlagD <= lowFlag;
            graphD <= graphIn;
        end
    end

    // second stage splits the set.
    always_ff @(posedge clk) begin
        if (clkEnDSingletons[1]) begin
            singletons <= graphD & ~hasNeighbor;
        end
        if (clkEnDNonSingletons[1]) begin
            if (zeroNonSingletons) begin
                nonSingletons <= '0;
            end else begin
                nonSingletons <= graphD & hasNeighbor;
            end
        end
    end

endmodule

// ==== singletonPopcnt.sv ====
`timescale 1ns/1ps

module singletonPopcnt (
    input  logic                              clk,
    input  logic [ccPkg::VERTEX_COUNT-1:0]    singletons,
    output logic [ccPkg::SINGLETON_WIDTH-1:0] singletonCount
);

    localparam int HALF = ccPkg::VERTEX_COUNT / 2;
    localparam int GROUPS = HALF / 4;

    // vertices 2i and 2i+1 are neighbours, so at most one of them is a singleton.
    logic [HALF-1:0] halved;

    // each group covers a 3-cube and holds at most four singletons.
    logic [2:0] groupSum [GROUPS];
    logic [3:0] pairSum [GROUPS/2];
    logic [4:0] quadSum [GROUPS/4];
    logic [5:0] octSum [GROUPS/8];

    for (genvar i = 0; i < HALF; i++) begin : gHalve
        assign halved[i] = singletons[2*i] | singletons[2*i+1];
    end

    // cycle 1.
    // lookup table instead of a four-input adder.
    for (genvar i = 0; i < GROUPS; i++) begin : gLut
        always_ff @(posedge clk) begin
            case (halved[4*i +: 4])
                4'b0000: groupSum[i] <= 3'd0;
                4'b0001: groupSum[i] <= 3'd1;
                4'b0010: groupSum[i] <= 3'd1;
                4'b0011: groupSum[i] <= 3'd2;
                4'b0100: groupSum[i] <= 3'd1;
                4'b0101: groupSum[i] <= 3'd2;
                4'b0110: groupSum[i] <= 3'd2;
                4'b0111: groupSum[i] <= 3'd3;
                4'b1000: groupSum[i] <= 3'd1;
                4'b1001: groupSum[i] <= 3'd2;
                4'b1010: groupSum[i] <= 3'd2;
                4'b1011: groupSum[i] <= 3'd3;
                4'b1100: groupSum[i] <= 3'd2;
                4'b1101: groupSum[i] <= 3'd3;
                4'b1110: groupSum[i] <= 3'd3;
                default: groupSum[i] <= 3'd4;
            endcase
        end
    end

    // first adder level is combinational and folds into cycle 2.
    for (genvar i = 0; i < GROUPS/2; i++) begin : gPair
        assign pairSum[i] = 4'(groupSum[2*i]) + 4'(groupSum[2*i+1]);
    end

    // cycle 2.
    for (genvar i = 0; i < GROUPS/4; i++) begin : gQuad
        always_ff @(posedge clk) begin
            quadSum[i] <= 5'(pairSum[2*i]) + 5'(pairSum[2*i+1]);
        end
    end

    // cycle 3.
    for (genvar i = 0; i < GROUPS/8; i++) begin : gOct
        always_ff @(posedge clk) begin
            octSum[i] <= 6'(quadSum[2*i]) + 6'(quadSum[2*i+1]);
        end
    end

    // cycle 4.
    always_ff @(posedge clk) begin
        singletonCount <= ccPkg::SINGLETON_WIDTH'(octSum[0])
            + ccPkg::SINGLETON_WIDTH'(octSum[1]);
    end

endmodule

// ==== componentExplorer.sv ====
`timescale 1ns/1ps

module componentExplorer (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           explorerLoad,
    input  logic [ccPkg::VERTEX_COUNT-1:0] vertices,
    output logic                           componentClosed,
    output logic                           explorerIdle
);

    // vertices not yet assigned to any component.
    logic [ccPkg::VERTEX_COUNT-1:0] remaining;
    // component currently being grown.
    logic [ccPkg::VERTEX_COUNT-1:0] component;

    logic [ccPkg::VERTEX_COUNT-1:0] frontier;
    logic [ccPkg::VERTEX_COUNT-1:0] growth;
    logic [ccPkg::VERTEX_COUNT-1:0] seed;

    // a vertex is on the frontier when any of its seven neighbours is in the component.
    for (genvar vtx = 0; vtx < ccPkg::VERTEX_COUNT; vtx++) begin : gVertex
        logic [ccPkg::DIMENSION-1:0] adjacent;

        for (genvar d = 0; d < ccPkg::DIMENSION; d++) begin : gDim
            assign adjacent[d] = component[vtx ^ (1 << d)];
        end

        assign frontier[vtx] = |adjacent;
    end

    assign growth = remaining & frontier;

    // two's complement trick isolates the lowest set bit.
    assign seed = remaining & (~remaining + 1'b1);

    assign explorerIdle = (remaining == '0) && (component == '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remaining <= '0;
            component <= '0;
            componentClosed <= 1'b0;
        end else begin
            componentClosed <= 1'b0;
            if (explorerLoad) begin
                remaining <= vertices;
                component <= '0;
            end else if (component == '0) begin
                // start a new component at the lowest remaining vertex.
                if (remaining != '0) begin
                    component <= seed;
                    remaining <= remaining & ~seed;
                end
            end else if (growth == '0) begin
                // nothing left to reach, so the component is complete.
                componentClosed <= 1'b1;
                component <= '0;
            end else begin
                component <= component | growth;
                remaining <= remaining & ~growth;
            end
        end
    end

endmodule

// ==== componentCountControl.sv ====
`timescale 1ns/1ps

module componentCountControl (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              start,
    input  logic [ccPkg::VERTEX_COUNT-1:0]    graphIn,
    input  logic                              countSingletonsOnly,
    input  logic [ccPkg::SINGLETON_WIDTH-1:0] popCount,
    input  logic                              componentClosed,
    input  logic                              explorerIdle,
    output logic [ccPkg::VERTEX_COUNT-1:0]    graph,
    output logic                              clkEnPre,
    output logic                              zeroNonSingletons,
    output logic                              explorerLoad,
    output logic                              busy,
    output logic                              done,
    output logic [ccPkg::SINGLETON_WIDTH-1:0] singletonCount,
    output logic [ccPkg::COMPONENT_WIDTH-1:0] componentCount
);

    // cycles from clkEnPre until the singleton count is valid.
    localparam int WAIT_TOTAL = ccPkg::SPLIT_LATENCY + ccPkg::POPCNT_LATENCY;
    localparam int CYCLE_WIDTH = $clog2(WAIT_TOTAL + 1);

    ccPkg::ctrlState state;

    logic [CYCLE_WIDTH-1:0]            cycleCount;
    logic [ccPkg::COMPONENT_WIDTH-1:0] tally;
    logic [ccPkg::SINGLETON_WIDTH-1:0] popHold;

    // graph is held stable for the whole job.
    always_ff @(posedge clk) begin
        if (state == ccPkg::IDLE && start) begin
            graph <= graphIn;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ccPkg::WAIT_COUNT && cycleCount == CYCLE_WIDTH'(WAIT_TOTAL)) begin
            popHold <= popCount;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ccPkg::IDLE;
            cycleCount <= '0;
            tally <= '0;
            clkEnPre <= 1'b0;
            zeroNonSingletons <= 1'b0;
            explorerLoad <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            singletonCount <= '0;
            componentCount <= '0;
        end else begin
            clkEnPre <= 1'b0;
            explorerLoad <= 1'b0;
            done <= 1'b0;

            // saturating cycle counter started by clkEnPre.
            if (state != ccPkg::IDLE && cycleCount != CYCLE_WIDTH'(WAIT_TOTAL)) begin
                cycleCount <= cycleCount + 1'b1;
            end

            case (state)
                ccPkg::IDLE: begin
                    if (start) begin
                        zeroNonSingletons <= countSingletonsOnly;
                        busy <= 1'b1;
                        tally <= '0;
                        cycleCount <= '0;
                        clkEnPre <= 1'b1;
                        state <= ccPkg::SPLIT;
                    end
                end
                ccPkg::SPLIT: begin
                    // load lands on the edge after the split outputs settle.
                    if (cycleCount == CYCLE_WIDTH'(ccPkg::SPLIT_LATENCY - 1)) begin
                        explorerLoad <= 1'b1;
                        state <= ccPkg::EXPLORE;
                    end
                end
                ccPkg::EXPLORE: begin
                    if (componentClosed) begin
                        tally <= tally + 1'b1;
                    end
                    // the explorer still shows the previous job while the load is pending.
                    if (!explorerLoad && explorerIdle) begin
                        state <= ccPkg::WAIT_COUNT;
                    end
                end
                ccPkg::WAIT_COUNT: begin
                    if (cycleCount == CYCLE_WIDTH'(WAIT_TOTAL)) begin
                        state <= ccPkg::FINISH;
                    end
                end
                ccPkg::FINISH: begin
                    singletonCount <= popHold;
                    componentCount <= ccPkg::COMPONENT_WIDTH'(popHold) + tally;
                    done <= 1'b1;
                    busy <= 1'b0;
                    state <= ccPkg::IDLE;
                end
                default: begin
                    state <= ccPkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== componentCounterTop.sv ====
`timescale 1ns/1ps

module componentCounterTop (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              start,
    input  logic [ccPkg::VERTEX_COUNT-1:0]    graphIn,
    input  logic                              countSingletonsOnly,
    output logic                              busy,
    output logic                              done,
    output logic [ccPkg::SINGLETON_WIDTH-1:0] singletonCount,
    output logic [ccPkg::COMPONENT_WIDTH-1:0] componentCount
);

    logic [ccPkg::VERTEX_COUNT-1:0]    graph;
    logic                              clkEnPre;
    logic                              zeroNonSingletons;
    logic                              explorerLoad;
    logic [ccPkg::VERTEX_COUNT-1:0]    singletons;
    logic [ccPkg::VERTEX_COUNT-1:0]    nonSingletons;
    logic [ccPkg::SINGLETON_WIDTH-1:0] popCount;
    logic                              componentClosed;
    logic                              explorerIdle;

    componentCountControl control (
        .clk                (clk),
        .arstN              (arstN),
        .start              (start),
        .graphIn            (graphIn),
        .countSingletonsOnly(countSingletonsOnly),
        .popCount           (popCount),
        .componentClosed    (componentClosed),
        .explorerIdle       (explorerIdle),
        .graph              (graph),
        .clkEnPre           (clkEnPre),
        .zeroNonSingletons  (zeroNonSingletons),
        .explorerLoad       (explorerLoad),
        .busy               (busy),
        .done               (done),
        .singletonCount     (singletonCount),
        .componentCount     (componentCount)
    );

    singletonSplitter splitter (
        .clk              (clk),
        .clkEnPre         (clkEnPre),
        .zeroNonSingletons(zeroNonSingletons),
        .graphIn          (graph),
        .singletons       (singletons),
        .nonSingletons    (nonSingletons)
    );

    singletonPopcnt popcnt (
        .clk           (clk),
        .singletons    (singletons),
        .singletonCount(popCount)
    );

    componentExplorer explorer (
        .clk            (clk),
        .arstN          (arstN),
        .explorerLoad   (explorerLoad),
        .vertices       (nonSingletons),
        .componentClosed(componentClosed),
        .explorerIdle   (explorerIdle)
    );

endmodule

// ==== tb_componentCounter.sv ====
`timescale 1ns/1ps

module tb_componentCounter;

    localparam int HALF_PERIOD = 2;
    localparam int CLK_PERIOD = 2 * HALF_PERIOD;
    localparam int DONE_LIMIT = 300;
    // jobs started over the whole run, used to size the watchdog.
    localparam int JOB_COUNT = 35;

    logic                              clk;
    logic                              arstN;
    logic                              start;
    logic [ccPkg::VERTEX_COUNT-1:0]    graphIn;
    logic                              countSingletonsOnly;
    logic                              busy;
    logic                              done;
    logic [ccPkg::SINGLETON_WIDTH-1:0] singletonCount;
    logic [ccPkg::COMPONENT_WIDTH-1:0] componentCount;

    logic [31:0] lfsrState = 32'h0ee9_a5f5;
    int          jobCount = 0;
    int          doneCount = 0;

    componentCounterTop uut (
        .clk                (clk),
        .arstN              (arstN),
        .start              (start),
        .graphIn            (graphIn),
        .countSingletonsOnly(countSingletonsOnly),
        .busy               (busy),
        .done               (done),
        .singletonCount     (singletonCount),
        .componentCount     (componentCount)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // every job gets the full per-job budget plus one for reset.
    initial begin
        #((JOB_COUNT + 1) * DONE_LIMIT * CLK_PERIOD);
        $display("watchdog expired: the run took longer than its time budget");
        abortRun();
    end

    always @(negedge clk) begin
        if (done === 1'b1) begin
            doneCount <= doneCount + 1;
        end
    end

    task automatic abortRun;
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            abortRun();
        end
    endtask

    // 32-bit Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic takeBit(output logic b);
        b = lfsrState[0];
        lfsrState = lfsrStep(lfsrState);
    endtask

    // a vertex survives only when two bits are both one.
    task automatic randomGraph(output logic [ccPkg::VERTEX_COUNT-1:0] g);
        logic a;
        logic b;
        for (int v = 0; v < ccPkg::VERTEX_COUNT; v++) begin
            takeBit(a);
            takeBit(b);
            g[v] = a & b;
        end
    endtask

    // breadth-first search over the 7-cube.
    task automatic modelCount(input logic [ccPkg::VERTEX_COUNT-1:0] g,
                              output int singles, output int comps);
        logic [ccPkg::VERTEX_COUNT-1:0] seen;
        int pending [$];
        int v;
        int n;
        int degree;
        singles = 0;
        comps = 0;
        seen = '0;
        for (int s = 0; s < ccPkg::VERTEX_COUNT; s++) begin
            if (g[s] && !seen[s]) begin
                comps++;
                seen[s] = 1'b1;
                pending.push_back(s);
                while (pending.size() > 0) begin
                    v = pending.pop_front();
                    degree = 0;
                    for (int d = 0; d < ccPkg::DIMENSION; d++) begin
                        n = v ^ (1 << d);
                        if (g[n]) begin
                            degree++;
                            if (!seen[n]) begin
                                seen[n] = 1'b1;
                                pending.push_back(n);
                            end
                        end
                    end
                    if (degree == 0) singles++;
                end
            end
        end
    endtask

    task automatic startJob(input logic [ccPkg::VERTEX_COUNT-1:0] g, input logic mode);
        @(posedge clk);
        graphIn <= g;
        countSingletonsOnly <= mode;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        jobCount++;
    endtask

    task automatic awaitDone;
        int cycles;
        ccPkg::ctrlState st;
        cycles = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (cycles == DONE_LIMIT) begin
                st = uut.control.state;
                $display("no done pulse within %0d cycles, controller stuck in %s",
                         DONE_LIMIT, st.name());
                abortRun();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic checkResult(input logic [ccPkg::VERTEX_COUNT-1:0] g, input logic mode);
        int singles;
        int comps;
        modelCount(g, singles, comps);
        checkValue("singletonCount", singles, singletonCount);
        // in singletons-only mode the explorer sees an empty set.
        checkValue("componentCount", mode ? singles : comps, componentCount);
        checkValue("busy", 0, busy);
        @(negedge clk);
        checkValue("doneCount", jobCount, doneCount);
    endtask

    task automatic runJob(input logic [ccPkg::VERTEX_COUNT-1:0] g, input logic mode);
        startJob(g, mode);
        awaitDone();
        checkResult(g, mode);
    endtask

    task automatic testResetAndEmpty;
        @(negedge clk);
        checkValue("busy", 0, busy);
        checkValue("done", 0, done);
        checkValue("singletonCount", 0, singletonCount);
        checkValue("componentCount", 0, componentCount);
        runJob('0, 1'b0);
    endtask

    task automatic testEvenParity;
        logic [ccPkg::VERTEX_COUNT-1:0] g;
        for (int v = 0; v < ccPkg::VERTEX_COUNT; v++) begin
            g[v] = ~^v[6:0];
        end
        runJob(g, 1'b0);
    endtask

    task automatic testHandBuilt;
        // square over dimensions 5 and 6, two upper pairs and a loner.
        int upperList [9] = '{0, 32, 64, 96, 3, 35, 5, 69, 10};
        int pathList [13] = '{0, 1, 3, 7, 15, 31, 63, 127, 126, 124, 120, 112, 96};
        int mixedList [9] = '{0, 1, 20, 22, 100, 116, 7, 127, 56};
        logic [ccPkg::VERTEX_COUNT-1:0] g;
        runJob('1, 1'b0);
        g = '0;
        foreach (upperList[i]) g[upperList[i]] = 1'b1;
        runJob(g, 1'b0);
        g = '0;
        foreach (pathList[i]) g[pathList[i]] = 1'b1;
        runJob(g, 1'b0);
        g = '0;
        foreach (mixedList[i]) g[mixedList[i]] = 1'b1;
        runJob(g, 1'b0);
    endtask

    task automatic testRandom(input int count, input logic mode);
        logic [ccPkg::VERTEX_COUNT-1:0] g;
        repeat (count) begin
            randomGraph(g);
            runJob(g, mode);
        end
    endtask

    // a second start with another graph and mode lands mid-job.
    task automatic testStartWhileBusy;
        logic [ccPkg::VERTEX_COUNT-1:0] g;
        randomGraph(g);
        startJob(g, 1'b0);
        @(posedge clk);
        graphIn <= '1;
        countSingletonsOnly <= 1'b1;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        awaitDone();
        checkResult(g, 1'b0);
        repeat (20) @(negedge clk);
        checkValue("doneCount", jobCount, doneCount);
        checkValue("busy", 0, busy);
    endtask

    initial begin
        arstN = 1'b0;
        start = 1'b0;
        graphIn = '0;
        countSingletonsOnly = 1'b0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        testResetAndEmpty();
        testEvenParity();
        testHandBuilt();
        testRandom(20, 1'b0);
        testRandom(8, 1'b1);
        testStartWhileBusy();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
ccPkg.sv
singletonSplitter.sv
singletonPopcnt.sv
componentExplorer.sv
componentCountControl.sv
componentCounterTop.sv
tb_componentCounter.sv

// ==== Bender.yml ====
package:
  name: component_counter

sources:
  - ccPkg.sv
  - singletonSplitter.sv
  - singletonPopcnt.sv
  - componentExplorer.sv
  - componentCountControl.sv
  - componentCounterTop.sv
  - target: test
    files:
      - tb_componentCounter.sv
